// ==== logic/alu_pkg.sv ====
// Shared opcodes, operand view and struct types for the execute stage; referenced by scoped name
package alu_pkg;

    // Opcode encoding of the instruction set
    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,
        OP_SUB    = 4'h1,
        OP_XOR    = 4'h2,
        OP_RED    = 4'h3,
        OP_SLL    = 4'h4,
        OP_SRA    = 4'h5,
        OP_ROR    = 4'h6,
        OP_PADDSB = 4'h7,
        OP_LW     = 4'h8,
        OP_SW     = 4'h9,
        OP_LLB    = 4'hA,
        OP_LHB    = 4'hB,
        OP_PCS    = 4'hE
    } alu_op_e;

    // One operand word, read whole or as four nibbles
    typedef union packed {
        logic [15:0]      word;
        logic [3:0][3:0]  nib; // nib[0] is bits 3:0
    } operand_u;

    // One operation entering the stage
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        operand_u  rs;
        operand_u  rt;
    } alu_req_t;

    // Condition flags
    typedef struct packed {
        logic n; // Negative
        logic v; // Signed overflow
        logic z; // Zero
    } alu_flags_t;

    // Per-flag write enables
    typedef struct packed {
        logic n_we;
        logic v_we;
        logic z_we;
    } alu_flag_we_t;

    // Adder function select
    typedef enum logic [1:0] {
        ADD_SAT = 2'd0,
        SUB_SAT = 2'd1,
        RED     = 2'd2,
        PADDSB  = 2'd3
    } add_mode_e;

    // Shifter function select, code 3 is unused
    typedef enum logic [1:0] {
        SLL = 2'd0,
        SRA = 2'd1,
        ROR = 2'd2
    } shift_mode_e;

    // Registered stage output
    typedef struct packed {
        logic        valid;
        logic [15:0] rd;
        alu_flags_t  flags;
    } alu_rsp_t;

endpackage

// ==== logic/adder_multifunc.sv ====
// Combinational adder for saturating add/sub, byte reduction and nibble-parallel add; used by alu
`timescale 1ns/1ps

module adder_multifunc (
    input  alu_pkg::operand_u   a,
    input  alu_pkg::operand_u   b,
    input  alu_pkg::add_mode_e  mode,
    output logic [15:0]         s,
    output logic                ovfl
);

    logic              sub;
    logic [15:0]       b_eff;
    logic [15:0]       sum_word;
    logic              word_ovfl;
    logic [15:0]       word_sat;
    logic [9:0]        red_sum;
    logic [3:0][3:0]   nib_sat;

    assign sub   = (mode == alu_pkg::SUB_SAT);
    assign b_eff = sub ? ~b.word : b.word; // Invert for a - b

    // Carry-in of one completes the two's complement of b
    assign sum_word = a.word + b_eff + {15'd0, sub};

    // Overflow when both addends share a sign that the sum lost
    assign word_ovfl = (a.word[15] == b_eff[15]) && (sum_word[15] != a.word[15]);

    always_comb begin
        if (word_ovfl) begin
            word_sat = a.word[15] ? 16'h8000 : 16'h7FFF; // Clamp toward a's sign
        end else begin
            word_sat = sum_word;
        end
    end

    // Byte reduction tree, 10 bits cover four signed bytes
    assign red_sum = ({{2{a.word[15]}}, a.word[15:8]} + {{2{a.word[7]}}, a.word[7:0]})
                   + ({{2{b.word[15]}}, b.word[15:8]} + {{2{b.word[7]}}, b.word[7:0]});

    // Four independent saturating nibble adders
    for (genvar i = 0; i < 4; i++) begin : g_nib
        logic [3:0] raw;
        logic       nib_ovfl;

        assign raw      = a.nib[i] + b.nib[i];
        assign nib_ovfl = (a.nib[i][3] == b.nib[i][3]) && (raw[3] != a.nib[i][3]);
        assign nib_sat[i] = nib_ovfl ? (a.nib[i][3] ? 4'h8 : 4'h7) : raw;
    end

    always_comb begin
        case (mode)
            alu_pkg::ADD_SAT,
            alu_pkg::SUB_SAT: begin
                s    = word_sat;
                ovfl = word_ovfl;
            end
            alu_pkg::RED: begin
                s    = {{6{red_sum[9]}}, red_sum}; // Sign extend, never saturates
                ovfl = 1'b0;
            end
            alu_pkg::PADDSB: begin
                s    = nib_sat;
                ovfl = 1'b0; // Nibble clamps do not reach V
            end
            default: begin
                s    = sum_word;
                ovfl = 1'b0;
            end
        endcase
    end

    // A clamped result always keeps the sign of the first operand
    sat_sign_check: assert final (!ovfl || (s[15] == a.word[15]))
        else $error("adder saturated to the wrong sign");

endmodule

// ==== logic/shifter.sv ====
// Combinational four-stage barrel shifter for SLL, SRA and ROR; used by alu
`timescale 1ns/1ps

module shifter (
    input  logic [15:0]           shift_in,
    input  logic [3:0]            shamt,
    input  alu_pkg::shift_mode_e  mode,
    output logic [15:0]           shift_out
);

    logic [15:0] st1;
    logic [15:0] st2;
    logic [15:0] st4;
    logic [15:0] st8;

    // Stages by 1, 2, 4 and 8, each enabled by one shamt bit
    always_comb begin
        case (mode)
            alu_pkg::SLL: begin
                st1 = shamt[0] ? {shift_in[14:0], 1'b0} : shift_in;
                st2 = shamt[1] ? {st1[13:0], 2'b00}     : st1;
                st4 = shamt[2] ? {st2[11:0], 4'h0}      : st2;
                st8 = shamt[3] ? {st4[7:0], 8'h00}      : st4;
            end
            alu_pkg::SRA: begin
                st1 = shamt[0] ? {shift_in[15], shift_in[15:1]} : shift_in;
                st2 = shamt[1] ? {{2{st1[15]}}, st1[15:2]}      : st1;
                st4 = shamt[2] ? {{4{st2[15]}}, st2[15:4]}      : st2;
                st8 = shamt[3] ? {{8{st4[15]}}, st4[15:8]}      : st4;
            end
            alu_pkg::ROR: begin
                st1 = shamt[0] ? {shift_in[0], shift_in[15:1]} : shift_in;
                st2 = shamt[1] ? {st1[1:0], st1[15:2]}         : st1;
                st4 = shamt[2] ? {st2[3:0], st2[15:4]}         : st2;
                st8 = shamt[3] ? {st4[7:0], st4[15:8]}         : st4;
            end
            default: begin
                st1 = shift_in; // Unused mode passes through
                st2 = st1;
                st4 = st2;
                st8 = st4;
            end
        endcase
    end

    assign shift_out = st8;

    // Zero shift leaves the word untouched in every mode
    zero_shamt_check: assert final ((shamt != 4'd0) || (shift_out == shift_in))
        else $error("shift by zero changed the operand");

endmodule

// ==== logic/alu.sv ====
// Combinational 16-bit ALU that selects the result and decodes flags per opcode; used by alu_stage
`timescale 1ns/1ps

module alu (
    input  alu_pkg::alu_op_e       op,
    input  alu_pkg::operand_u      rs,
    input  alu_pkg::operand_u      rt,
    output logic [15:0]            rd,
    output alu_pkg::alu_flags_t    flags,
    output alu_pkg::alu_flag_we_t  flag_we
);

    alu_pkg::add_mode_e    add_mode;
    alu_pkg::shift_mode_e  shift_mode;
    logic [15:0]           add_out;
    logic                  ovfl;
    logic [15:0]           shift_out;
    logic [15:0]           xor_out;
    logic [15:0]           llb_out;
    logic [15:0]           lhb_out;

    adder_multifunc adder_inst (
        .a    (rs),
        .b    (rt),
        .mode (add_mode),
        .s    (add_out),
        .ovfl (ovfl)
    );

    shifter shifter_inst (
        .shift_in  (rs.word),
        .shamt     (rt.word[3:0]),
        .mode      (shift_mode),
        .shift_out (shift_out)
    );

    assign xor_out = rs.word ^ rt.word;
    assign llb_out = {rs.word[15:8], rt.word[7:0]}; // Replace low byte
    assign lhb_out = {rt.word[7:0], rs.word[7:0]};  // Replace high byte

    // LW and SW share the plain add
    always_comb begin
        case (op)
            alu_pkg::OP_SUB:    add_mode = alu_pkg::SUB_SAT;
            alu_pkg::OP_RED:    add_mode = alu_pkg::RED;
            alu_pkg::OP_PADDSB: add_mode = alu_pkg::PADDSB;
            default:            add_mode = alu_pkg::ADD_SAT;
        endcase
    end

    always_comb begin
        case (op)
            alu_pkg::OP_SRA: shift_mode = alu_pkg::SRA;
            alu_pkg::OP_ROR: shift_mode = alu_pkg::ROR;
            default:         shift_mode = alu_pkg::SLL;
        endcase
    end

    always_comb begin
        case (op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB,
            alu_pkg::OP_RED,
            alu_pkg::OP_PADDSB,
            alu_pkg::OP_LW,
            alu_pkg::OP_SW:     rd = add_out;
            alu_pkg::OP_XOR:    rd = xor_out;
            alu_pkg::OP_SLL,
            alu_pkg::OP_SRA,
            alu_pkg::OP_ROR:    rd = shift_out;
            alu_pkg::OP_LLB:    rd = llb_out;
            alu_pkg::OP_LHB:    rd = lhb_out;
            alu_pkg::OP_PCS:    rd = rt.word;
            default:            rd = 16'hDEAD; // Undefined opcode marker
        endcase
    end

    // Enables decide which of these values land
    assign flags.n = rd[15];
    assign flags.v = ovfl;
    assign flags.z = (rd == 16'h0000);

    always_comb begin
        flag_we = '0;
        case (op)
            alu_pkg::OP_ADD,
            alu_pkg::OP_SUB: begin
                flag_we.n_we = 1'b1;
                flag_we.v_we = 1'b1;
                flag_we.z_we = 1'b1;
            end
            alu_pkg::OP_XOR,
            alu_pkg::OP_SLL,
            alu_pkg::OP_SRA,
            alu_pkg::OP_ROR: flag_we.z_we = 1'b1; // Z only
            default:         flag_we = '0;
        endcase
    end

endmodule

// ==== logic/alu_stage.sv ====
// Execute stage top that registers the ALU result and holds the flag register for the pipeline
`timescale 1ns/1ps

module alu_stage (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::alu_req_t  req,
    output alu_pkg::alu_rsp_t  rsp
);

    logic [15:0]            alu_rd;
    alu_pkg::alu_flags_t    alu_flags;
    alu_pkg::alu_flag_we_t  alu_flag_we;

    logic                   valid_q;
    logic [15:0]            rd_q;
    alu_pkg::alu_flags_t    flags_q;

    alu alu_inst (
        .op      (req.op),
        .rs      (req.rs),
        .rt      (req.rt),
        .rd      (alu_rd),
        .flags   (alu_flags),
        .flag_we (alu_flag_we)
    );

    // Result visible the cycle after its request is sampled
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            rd_q    <= 16'h0000;
        end else begin
            valid_q <= req.valid;
            if (req.valid) begin
                rd_q <= alu_rd; // Hold last result on bubbles
            end
        end
    end

    // Each flag only moves when its opcode defines it
    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else if (req.valid) begin
            if (alu_flag_we.n_we) begin
                flags_q.n <= alu_flags.n;
            end
            if (alu_flag_we.v_we) begin
                flags_q.v <= alu_flags.v;
            end
            if (alu_flag_we.z_we) begin
                flags_q.z <= alu_flags.z;
            end
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.rd    = rd_q;
    assign rsp.flags = flags_q; // Already includes this result's update

    // Downstream has no stall, so an X valid would corrupt it
    rsp_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(rsp.valid)
    ) else $error("rsp.valid is unknown after reset");

    // A shift leaves a stale V from an earlier add in place
    shift_keeps_v: assert property (
        @(posedge clk) disable iff (reset)
        (req.valid && (req.op inside {alu_pkg::OP_SLL, alu_pkg::OP_SRA, alu_pkg::OP_ROR}))
            |=> $stable(flags_q.v)
    ) else $error("shift opcode changed the V flag");

endmodule

// ==== tb/alu_checker.sv ====
// Response checker for the execute stage testbench; compares each response with its queued expectation
`timescale 1ns/1ps

module alu_checker (
    input  logic               clk,
    input  logic               reset,
    input  alu_pkg::alu_rsp_t  rsp,
    input  alu_pkg::alu_rsp_t  expected,
    input  logic               report,
    output int                 checked,
    output int                 errors
);

    alu_pkg::alu_rsp_t  exp_q [$];
    alu_pkg::alu_rsp_t  head;
    int                 passes;
    int                 reset_edges;
    logic               reset_done;
    logic               reset_bad;

    initial begin
        checked     = 0;
        errors      = 0;
        passes      = 0;
        reset_edges = 0;
        reset_done  = 1'b0;
        reset_bad   = 1'b0;
    end

    task automatic check_idle();
        if (rsp.valid !== 1'b0) begin
            $display("FAIL rsp.valid exp 0 got %h", rsp.valid);
            reset_bad = 1'b1;
        end
        if (rsp.flags !== 3'b000) begin
            $display("FAIL rsp.flags exp 0 got %h", rsp.flags);
            reset_bad = 1'b1;
        end
    endtask

    task automatic compare_one(input alu_pkg::alu_rsp_t e);
        logic bad_rd;
        logic bad_fl;
        bad_rd = (rsp.rd !== e.rd);
        bad_fl = (rsp.flags !== e.flags);
        if (bad_rd && bad_fl) begin
            $display("FAIL rd exp %h got %h, flags exp %h got %h (test %0d)",
                     e.rd, rsp.rd, e.flags, rsp.flags, checked);
        end else if (bad_rd) begin
            $display("FAIL rd exp %h got %h (test %0d)", e.rd, rsp.rd, checked);
        end else if (bad_fl) begin
            $display("FAIL flags exp %h got %h (test %0d)", e.flags, rsp.flags, checked);
        end else begin
            $display("PASS test %0d rd %h flags %h", checked, rsp.rd, rsp.flags);
        end
        if (bad_rd || bad_fl) errors++; else passes++;
        checked++;
    endtask

    // A response must come exactly one edge after its request
    always @(posedge clk) begin
        if (reset) begin
            reset_edges++;
            if (reset_edges > 1) check_idle(); // First edge still shows power-up X
        end else if (!reset_done) begin
            check_idle();
            reset_done = 1'b1;
            if (reset_bad) errors++; else passes++;
            if (!reset_bad) $display("PASS reset values");
        end else if (rsp.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Extra response with rd %h arrived with no request pending", rsp.rd);
                errors++;
            end else begin
                head = exp_q.pop_front();
                compare_one(head);
            end
        end else if (exp_q.size() != 0) begin
            head = exp_q.pop_front();
            $display("Response for test %0d did not arrive in the cycle after its request",
                     checked);
            errors++;
            checked++;
        end
        if (!reset && expected.valid) exp_q.push_back(expected);
    end

    always @(posedge report) begin
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            errors += exp_q.size();
        end
        $display("Tests passed %0d, failed %0d", passes, errors);
    end

endmodule

// ==== tb/alu_tb.sv ====
// Testbench top for the execute stage; feeds the stimulus table to the DUT and to alu_checker
`timescale 1ns/1ps

module alu_tb;

    localparam int NUM_FIXED  = 29;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_TESTS  = NUM_FIXED + NUM_RANDOM;

    // Flags hold the register value after the operation
    typedef struct packed {
        logic [3:0]           op;
        logic [15:0]          rs;
        logic [15:0]          rt;
        logic [15:0]          rd;
        alu_pkg::alu_flags_t  flags;
    } entry_t;

    logic               clk;
    logic               reset;
    alu_pkg::alu_req_t  req;
    alu_pkg::alu_rsp_t  rsp;
    alu_pkg::alu_rsp_t  expected; // Travels beside req to the checker
    logic               report;
    int                 checked;
    int                 errors;
    entry_t             stim [NUM_TESTS];
    int                 n_entries;
    logic [31:0]        rng;

    alu_stage alu_stage_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

    alu_checker checker_inst (
        .clk      (clk),
        .reset    (reset),
        .rsp      (rsp),
        .expected (expected),
        .report   (report),
        .checked  (checked),
        .errors   (errors)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_entry(input logic [3:0] op, input logic [15:0] rs, input logic [15:0] rt,
                             input logic [15:0] rd, input logic [2:0] flags);
        stim[n_entries] = {op, rs, rt, rd, flags};
        n_entries++;
    endtask

    // Reference behavior of one operation with flags updated in place
    task automatic compute_expected(input logic [3:0] op, input logic [15:0] rs,
                                    input logic [15:0] rt, inout alu_pkg::alu_flags_t fl,
                                    output logic [15:0] rd);
        int          r;
        int          nib;
        logic        sat;
        logic [31:0] dbl;
        sat = 1'b0;
        case (op)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_LW, alu_pkg::OP_SW: begin
                if (op == alu_pkg::OP_SUB) begin
                    r = $signed(rs) - $signed(rt);
                end else begin
                    r = $signed(rs) + $signed(rt);
                end
                sat = (r > 32767) || (r < -32768);
                rd  = (r > 32767) ? 16'h7FFF : ((r < -32768) ? 16'h8000 : r[15:0]);
            end
            alu_pkg::OP_XOR: rd = rs ^ rt;
            alu_pkg::OP_RED: begin
                r  = $signed(rs[15:8]) + $signed(rs[7:0]) + $signed(rt[15:8]) + $signed(rt[7:0]);
                rd = r[15:0];
            end
            alu_pkg::OP_PADDSB: begin
                for (int k = 0; k < 4; k++) begin
                    nib = $signed(rs[4*k +: 4]) + $signed(rt[4*k +: 4]);
                    nib = (nib > 7) ? 7 : ((nib < -8) ? -8 : nib); // Clamp per nibble
                    rd[4*k +: 4] = nib[3:0];
                end
            end
            alu_pkg::OP_SLL: rd = rs << rt[3:0];
            alu_pkg::OP_SRA: rd = $signed(rs) >>> rt[3:0];
            alu_pkg::OP_ROR: begin
                dbl = {rs, rs} >> rt[3:0];
                rd  = dbl[15:0];
            end
            alu_pkg::OP_LLB: rd = {rs[15:8], rt[7:0]};
            alu_pkg::OP_LHB: rd = {rt[7:0], rs[7:0]};
            alu_pkg::OP_PCS: rd = rt;
            default:         rd = 16'hDEAD;
        endcase
        if (op == alu_pkg::OP_ADD || op == alu_pkg::OP_SUB) begin
            fl.n = rd[15];
            fl.v = sat;
        end
        if (op inside {alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_XOR,
                       alu_pkg::OP_SLL, alu_pkg::OP_SRA, alu_pkg::OP_ROR}) begin
            fl.z = (rd == 16'h0000);
        end
    endtask

    task automatic build_table();
        alu_pkg::alu_flags_t fl;
        logic [3:0]          op;
        logic [15:0]         rs;
        logic [15:0]         rt;
        logic [15:0]         rd;
        n_entries = 0;
        add_entry(4'h0, 16'h7000, 16'h2000, 16'h7FFF, 3'b010); // Positive overflow
        add_entry(4'h1, 16'h8000, 16'h0001, 16'h8000, 3'b110); // Negative overflow
        add_entry(4'h1, 16'h1234, 16'h1234, 16'h0000, 3'b001);
        add_entry(4'h0, 16'h8000, 16'h8000, 16'h8000, 3'b110);
        add_entry(4'h4, 16'h8000, 16'h0001, 16'h0000, 3'b111); // Shift to zero sets Z
        add_entry(4'h7, 16'h7777, 16'h1111, 16'h7777, 3'b111); // Every nibble clamps
        add_entry(4'h3, 16'h7F7F, 16'h0101, 16'h0100, 3'b111);
        add_entry(4'h4, 16'h8001, 16'h0000, 16'h8001, 3'b110);
        add_entry(4'h4, 16'h8001, 16'h0001, 16'h0002, 3'b110);
        add_entry(4'h4, 16'h8001, 16'hFFF4, 16'h0010, 3'b110); // Upper rt bits ignored
        add_entry(4'h4, 16'h8001, 16'h000F, 16'h8000, 3'b110);
        add_entry(4'h5, 16'h8001, 16'h0000, 16'h8001, 3'b110);
        add_entry(4'h5, 16'h8001, 16'h0001, 16'hC000, 3'b110);
        add_entry(4'h5, 16'h8001, 16'h0004, 16'hF800, 3'b110);
        add_entry(4'h5, 16'h8001, 16'h000F, 16'hFFFF, 3'b110);
        add_entry(4'h6, 16'h8001, 16'h0000, 16'h8001, 3'b110);
        add_entry(4'h6, 16'h8001, 16'h0001, 16'hC000, 3'b110);
        add_entry(4'h6, 16'h8001, 16'h0004, 16'h1800, 3'b110);
        add_entry(4'h6, 16'h8001, 16'h000F, 16'h0003, 3'b110);
        add_entry(4'h2, 16'h5A5A, 16'hA5A5, 16'hFFFF, 3'b110);
        add_entry(4'h4, 16'h8000, 16'h0001, 16'h0000, 3'b111); // Z set again before the merges
        add_entry(4'hA, 16'hABCD, 16'h1234, 16'hAB34, 3'b111);
        add_entry(4'hB, 16'hABCD, 16'h1234, 16'h34CD, 3'b111);
        add_entry(4'hE, 16'hABCD, 16'h1234, 16'h1234, 3'b111);
        add_entry(4'hC, 16'h1111, 16'h2222, 16'hDEAD, 3'b111);
        add_entry(4'hD, 16'h1111, 16'h2222, 16'hDEAD, 3'b111);
        add_entry(4'hF, 16'h1111, 16'h2222, 16'hDEAD, 3'b111);
        add_entry(4'h8, 16'h0100, 16'h0020, 16'h0120, 3'b111);
        add_entry(4'h9, 16'h7FFF, 16'h0001, 16'h7FFF, 3'b111); // Saturates with flags kept
        fl = stim[n_entries - 1].flags;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng = xorshift(rng);
            op  = rng[3:0];
            rs  = rng[31:16];
            rng = xorshift(rng);
            rt  = rng[15:0];
            compute_expected(op, rs, rt, fl, rd);
            add_entry(op, rs, rt, rd, fl);
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        req      = '0;
        expected = '0;
        report   = 1'b0;
        rng      = 32'd46780;
        build_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            req.valid      = 1'b1;
            req.op         = alu_pkg::alu_op_e'(stim[i].op);
            req.rs.word    = stim[i].rs;
            req.rt.word    = stim[i].rt;
            expected.valid = 1'b1;
            expected.rd    = stim[i].rd;
            expected.flags = stim[i].flags;
            @(posedge clk);
            #1;
        end
        req      = '0;
        expected = '0;
        wait (checked == NUM_TESTS);
        repeat (3) @(posedge clk); // Room for stray responses
        #1;
        report = 1'b1;
        @(posedge clk);
        #1;
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((NUM_TESTS + 20) * 20);
        $display("Run timed out before all %0d tests finished", NUM_TESTS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== build.f ====
logic/alu_pkg.sv
logic/adder_multifunc.sv
logic/shifter.sv
logic/alu.sv
logic/alu_stage.sv
tb/alu_checker.sv
tb/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu_stage

sources:
  - files:
      - logic/alu_pkg.sv
      - logic/adder_multifunc.sv
      - logic/shifter.sv
      - logic/alu.sv
      - logic/alu_stage.sv
  - target: test
    files:
      - tb/alu_checker.sv
      - tb/alu_tb.sv
